/* list.f */
bpPkg.sv
resolveIf.sv
resolveCapture.sv
targetBuffer.sv
historyTable.sv
patternTable.sv
nextPcSelect.sv
localPredictor.sv
tbLocalPredictor.sv

/* tbLocalPredictor.sv */
`timescale 1ns/10ps
`default_nettype none

module tbLocalPredictor;

    localparam int cycleLimit        = 1200;   // about 520 cycles of stimulus plus margin
    localparam int randomResolutions = 300;
    localparam bpPkg::addrT loopPc     = 32'h0000_0440;
    localparam bpPkg::addrT loopTarget = 32'h0000_0400;
    // last entry shares its index with the first but has another tag
    localparam bpPkg::addrT branchPcs [5] = '{32'h0000_1000, 32'h0000_1044,
        32'h0000_10c8, 32'h0000_1230, 32'h0040_1000};

    logic                       clk;
    logic                       reset;
    bpPkg::addrT                ifPc;
    logic                       ifPred;
    logic                       ifPredValid;
    logic                       stall;
    logic                       exBranch;
    bpPkg::addrT                exPc;
    logic                       taken;
    bpPkg::addrT                branchTarget;
    bpPkg::addrT                pcNext;
    logic                       predTaken;
    logic                       predValid;
    logic [bpPkg::cntWidth-1:0] branchCount;
    logic [bpPkg::cntWidth-1:0] mispredictCount;

    // reference model of the three tables
    logic                        validM [bpPkg::tableDepth];
    logic [bpPkg::tagWidth-1:0]  tagM [bpPkg::tableDepth];
    bpPkg::addrT                 targetM [bpPkg::tableDepth];
    logic [bpPkg::histWidth-1:0] histM [bpPkg::tableDepth];
    bpPkg::ctrT                  phtM [bpPkg::phtDepth];
    logic                        upValidM;
    bpPkg::addrT                 upPcM;
    bpPkg::addrT                 upTargetM;
    logic                        upTakenM;
    bpPkg::addrT                 pcPlus4M;
    logic [bpPkg::cntWidth-1:0]  expBranchCount;
    logic [bpPkg::cntWidth-1:0]  expMispredictCount;

    // expected outputs for the current cycle
    logic [bpPkg::indexWidth-1:0] fetchIdx;
    logic                         expRedirect;
    logic                         expPredValid;
    logic                         expPredTaken;
    bpPkg::addrT                  expRedirectPc;
    bpPkg::addrT                  expTarget;
    bpPkg::addrT                  expPcNext;

    int pcErrors = 0;
    int predErrors = 0;
    int countErrors = 0;
    int cycles = 0;
    int resolved;

    localPredictor dut (
        .clk             (clk),
        .reset           (reset),
        .ifPc            (ifPc),
        .ifPred          (ifPred),
        .ifPredValid     (ifPredValid),
        .stall           (stall),
        .exBranch        (exBranch),
        .exPc            (exPc),
        .taken           (taken),
        .branchTarget    (branchTarget),
        .pcNext          (pcNext),
        .predTaken       (predTaken),
        .predValid       (predValid),
        .branchCount     (branchCount),
        .mispredictCount (mispredictCount)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // word index is fetch bits 9:2 and the tag is everything above
    function automatic logic [bpPkg::indexWidth-1:0] indexOf(input bpPkg::addrT a);
        return a[9:2];
    endfunction

    function automatic logic [bpPkg::tagWidth-1:0] tagOf(input bpPkg::addrT a);
        return a[31:10];
    endfunction

    function automatic bpPkg::ctrT stepCounter(input bpPkg::ctrT c, input logic up);
        if (up)
            return (c == 2'b11) ? c : c + 2'd1;
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    function automatic bpPkg::addrT randomPc();
        return bpPkg::addrT'($urandom) & 32'hffff_fffc;
    endfunction

    always_comb begin
        fetchIdx      = indexOf(ifPc);
        expPredValid  = validM[fetchIdx] && (tagM[fetchIdx] == tagOf(ifPc));
        expPredTaken  = phtM[histM[fetchIdx]][1];
        expTarget     = targetM[fetchIdx];
        // a miss counts as a not-taken prediction
        expRedirect   = exBranch && ((!ifPredValid && taken) || (ifPredValid && ifPred != taken));
        expRedirectPc = taken ? branchTarget : exPc + 32'd4;
        if (!reset)
            expPcNext = '0;
        else if (stall)
            expPcNext = ifPc;
        else if (expRedirect)
            expPcNext = expRedirectPc;
        else if (expPredValid && expPredTaken)
            expPcNext = expTarget;
        else
            expPcNext = pcPlus4M;
    end

    always @(posedge clk) begin : modelUpdate
        logic [bpPkg::indexWidth-1:0] trainIdx;
        logic [bpPkg::histWidth-1:0]  trainHist;
        trainIdx  = indexOf(upPcM);
        trainHist = histM[trainIdx];
        if (!reset) begin
            for (int i = 0; i < bpPkg::tableDepth; i++) begin
                validM[i] <= 1'b0;
                histM[i]  <= '0;
            end
            for (int i = 0; i < bpPkg::phtDepth; i++)
                phtM[i] <= 2'b01;
            upValidM           <= 1'b0;
            pcPlus4M           <= 32'd4;
            expBranchCount     <= '0;
            expMispredictCount <= '0;
        end else begin
            if (upValidM) begin   // training one edge after capture
                if (upTakenM) begin
                    validM[trainIdx]  <= 1'b1;
                    tagM[trainIdx]    <= tagOf(upPcM);
                    targetM[trainIdx] <= upTargetM;
                end
                histM[trainIdx] <= {trainHist[2:0], upTakenM};
                phtM[trainHist] <= stepCounter(phtM[trainHist], upTakenM);
            end
            upValidM  <= exBranch;
            upPcM     <= exPc;
            upTargetM <= branchTarget;
            upTakenM  <= taken;
            pcPlus4M  <= expPcNext + 32'd4;
            if (exBranch)
                expBranchCount <= expBranchCount + 1'b1;
            if (expRedirect)
                expMispredictCount <= expMispredictCount + 1'b1;
        end
    end

    task automatic logMismatch(input string name, input logic [31:0] expVal,
                               input logic [31:0] actVal);
        $display("** Error at %0t: %s expected %h, actual %h", $time, name, expVal, actVal);
    endtask

    pcNextCheck: assert property (@(posedge clk) pcNext === expPcNext)
        else begin
            pcErrors++;
            logMismatch("pcNext", $sampled(expPcNext), $sampled(pcNext));
        end

    predValidCheck: assert property (@(posedge clk) disable iff (!reset)
        predValid === expPredValid)
        else begin
            predErrors++;
            logMismatch("predValid", $sampled(expPredValid), $sampled(predValid));
        end

    predTakenCheck: assert property (@(posedge clk) disable iff (!reset)
        predTaken === expPredTaken)
        else begin
            predErrors++;
            logMismatch("predTaken", $sampled(expPredTaken), $sampled(predTaken));
        end

    targetCheck: assert property (@(posedge clk) disable iff (!reset)
        expPredValid |-> dut.btbTarget === expTarget)
        else begin
            predErrors++;
            logMismatch("btbTarget", $sampled(expTarget), $sampled(dut.btbTarget));
        end

    branchCountCheck: assert property (@(posedge clk) disable iff (!reset)
        branchCount === expBranchCount)
        else begin
            countErrors++;
            logMismatch("branchCount", $sampled(expBranchCount), $sampled(branchCount));
        end

    mispredictCountCheck: assert property (@(posedge clk) disable iff (!reset)
        mispredictCount === expMispredictCount)
        else begin
            countErrors++;
            logMismatch("mispredictCount", $sampled(expMispredictCount),
                        $sampled(mispredictCount));
        end

    task automatic printSummary();
        $display("errors: %0d (pcNext %0d, prediction %0d, counts %0d) after %0d cycles",
                 pcErrors + predErrors + countErrors, pcErrors, predErrors, countErrors,
                 cycles);
    endtask

    task automatic branchCycle(input bpPkg::addrT pc, input bpPkg::addrT target,
                               input logic isTaken, input logic predV, input logic pred);
        @(posedge clk);
        exBranch     <= 1'b1;
        exPc         <= pc;
        branchTarget <= target;
        taken        <= isTaken;
        ifPredValid  <= predV;
        ifPred       <= pred;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            exBranch <= 1'b0;
            stall    <= 1'b0;
        end
    endtask

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("run stopped: cycle limit of %0d reached before the tests ended", cycleLimit);
            printSummary();
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(83));
        reset        = 1'b0;
        ifPc         = '0;
        ifPred       = 1'b0;
        ifPredValid  = 1'b0;
        stall        = 1'b0;
        exBranch     = 1'b0;
        exPc         = '0;
        taken        = 1'b0;
        branchTarget = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b1;

        // sequential fetch with nothing learned yet
        repeat (16) begin
            @(posedge clk);
            ifPc <= randomPc();
        end

        // stall overrides everything
        repeat (12) begin
            @(posedge clk);
            stall        <= 1'b1;
            ifPc         <= randomPc();
            exBranch     <= 1'($urandom % 2);
            exPc         <= randomPc();
            branchTarget <= randomPc();
            taken        <= 1'($urandom % 2);
            ifPredValid  <= 1'($urandom % 2);
            ifPred       <= 1'($urandom % 2);
        end
        idleCycles(1);

        branchCycle(32'h0000_0200, 32'h0000_0800, 1'b1, 1'b0, 1'b0);   // unpredicted taken
        idleCycles(1);
        branchCycle(32'h0000_0300, 32'h0000_0900, 1'b0, 1'b1, 1'b1);   // falls through
        idleCycles(1);

        // loop branch taken three times then exiting
        @(posedge clk);
        ifPc <= loopPc;
        repeat (10) begin
            repeat (3)
                branchCycle(loopPc, loopTarget, 1'b1, 1'($urandom % 2), 1'($urandom % 2));
            branchCycle(loopPc, loopTarget, 1'b0, 1'($urandom % 2), 1'($urandom % 2));
            idleCycles(2);
        end

        // random mix over a few branch addresses
        resolved = 0;
        while (resolved < randomResolutions) begin
            @(posedge clk);
            exBranch     <= ($urandom % 4) != 0;
            exPc         <= branchPcs[$urandom % 5];
            branchTarget <= randomPc();
            taken        <= ($urandom % 3) != 0;
            ifPc         <= branchPcs[$urandom % 5];
            ifPredValid  <= 1'($urandom % 2);
            ifPred       <= 1'($urandom % 2);
            stall        <= ($urandom % 8) == 0;
            if (exBranch)
                resolved++;
        end
        idleCycles(4);

        @(negedge clk);
        printSummary();
        if (pcErrors + predErrors + countErrors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* localPredictor.sv */
`timescale 1ns/10ps
`default_nettype none

module localPredictor (
    input  logic                       clk,
    input  logic                       reset,
    input  bpPkg::addrT                ifPc,
    input  logic                       ifPred,
    input  logic                       ifPredValid,
    input  logic                       stall,
    input  logic                       exBranch,
    input  bpPkg::addrT                exPc,
    input  logic                       taken,
    input  bpPkg::addrT                branchTarget,
    output bpPkg::addrT                pcNext,
    output logic                       predTaken,
    output logic                       predValid,
    output logic [bpPkg::cntWidth-1:0] branchCount,
    output logic [bpPkg::cntWidth-1:0] mispredictCount
);

    logic                        redirect;
    bpPkg::addrT                 redirectPc;
    bpPkg::addrT                 btbTarget;
    logic [bpPkg::histWidth-1:0] fetchHistory;
    logic [bpPkg::histWidth-1:0] trainHistory;

    resolveIf resolveBus ();

    resolveCapture uCapture (
        .clk             (clk),
        .reset           (reset),
        .exBranch        (exBranch),
        .taken           (taken),
        .exPc            (exPc),
        .branchTarget    (branchTarget),
        .ifPred          (ifPred),
        .ifPredValid     (ifPredValid),
        .redirect        (redirect),
        .redirectPc      (redirectPc),
        .branchCount     (branchCount),
        .mispredictCount (mispredictCount),
        .up              (resolveBus.source)
    );

    targetBuffer uBtb (
        .clk       (clk),
        .reset     (reset),
        .ifPc      (ifPc),
        .btbHit    (predValid),   // a hit is what makes the prediction valid
        .btbTarget (btbTarget),
        .up        (resolveBus.sink)
    );

    historyTable uBht (
        .clk          (clk),
        .reset        (reset),
        .ifPc         (ifPc),
        .fetchHistory (fetchHistory),
        .trainHistory (trainHistory),
        .up           (resolveBus.sink)
    );

    patternTable uPht (
        .clk          (clk),
        .reset        (reset),
        .fetchHistory (fetchHistory),
        .trainHistory (trainHistory),
        .predTaken    (predTaken),
        .up           (resolveBus.sink)
    );

    nextPcSelect uSelect (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .redirect   (redirect),
        .predTaken  (predTaken),
        .predValid  (predValid),
        .ifPc       (ifPc),
        .redirectPc (redirectPc),
        .btbTarget  (btbTarget),
        .pcNext     (pcNext)
    );

endmodule

`default_nettype wire

/* nextPcSelect.sv */
`timescale 1ns/10ps
`default_nettype none

module nextPcSelect (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        redirect,
    input  logic        predTaken,
    input  logic        predValid,
    input  bpPkg::addrT ifPc,
    input  bpPkg::addrT redirectPc,
    input  bpPkg::addrT btbTarget,
    output bpPkg::addrT pcNext
);

    bpPkg::addrT pcPlus4;      // sequential successor of the last pcNext
    bpPkg::addrT pcPredicted;
    bpPkg::addrT pcCorrected;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pcPlus4 <= bpPkg::pcResetValue + bpPkg::pcStep;
        end else begin
            pcPlus4 <= pcNext + bpPkg::pcStep;
        end
    end

    // execute stage correction overrides the prediction
    assign pcPredicted = (predValid && predTaken) ? btbTarget : pcPlus4;
    assign pcCorrected = redirect ? redirectPc : pcPredicted;

    always_comb begin
        if (!reset)
            pcNext = bpPkg::pcResetValue;
        else if (stall)
            pcNext = ifPc;            // hold fetch
        else
            pcNext = pcCorrected;
    end

    // a stall wins over redirect and prediction alike
    stallHolds: assert property (@(posedge clk) disable iff (!reset)
        stall |-> (pcNext == ifPc));

endmodule

`default_nettype wire

/* patternTable.sv */
`timescale 1ns/10ps
`default_nettype none

module patternTable (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [bpPkg::histWidth-1:0] fetchHistory,
    input  logic [bpPkg::histWidth-1:0] trainHistory,
    output logic                        predTaken,
    resolveIf.sink                      up
);

    bpPkg::ctrT [bpPkg::phtDepth-1:0] phtMem;   // shared by all branches
    bpPkg::ctrT                       trainCtr;
    bpPkg::ctrT                       nextCtr;

    assign trainCtr = phtMem[trainHistory];

    // saturating step toward the outcome
    always_comb begin
        nextCtr = trainCtr;
        if (up.upTaken) begin
            if (trainCtr != bpPkg::ctrStrongTaken)
                nextCtr = trainCtr + 1'b1;
        end else begin
            if (trainCtr != bpPkg::ctrStrongNotTaken)
                nextCtr = trainCtr - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < bpPkg::phtDepth; i++) begin
                phtMem[i] <= bpPkg::ctrWeakNotTaken;
            end
        end else if (up.upValid) begin
            phtMem[trainHistory] <= nextCtr;
        end
    end

    assign predTaken = (phtMem[fetchHistory] >= bpPkg::ctrWeakTaken);   // 10 and 11

    // table is frozen between resolutions
    phtQuiet: assert property (@(posedge clk) disable iff (!reset)
        !up.upValid |=> $stable(phtMem));

endmodule

`default_nettype wire

/* historyTable.sv */
`timescale 1ns/10ps
`default_nettype none

module historyTable (
    input  logic                        clk,
    input  logic                        reset,
    input  bpPkg::addrT                 ifPc,
    output logic [bpPkg::histWidth-1:0] fetchHistory,
    output logic [bpPkg::histWidth-1:0] trainHistory,
    resolveIf.sink                      up
);

    localparam int idxLo = 2;
    localparam int idxHi = idxLo + bpPkg::indexWidth - 1;

    // one shift register per branch slot
    logic [bpPkg::histWidth-1:0]  histMem [bpPkg::tableDepth];
    logic [bpPkg::indexWidth-1:0] fetchIdx;
    logic [bpPkg::indexWidth-1:0] trainIdx;

    assign fetchIdx = ifPc[idxHi:idxLo];
    assign trainIdx = up.upPc[idxHi:idxLo];

    assign fetchHistory = histMem[fetchIdx];
    assign trainHistory = histMem[trainIdx];   // value before this shift

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < bpPkg::tableDepth; i++) begin
                histMem[i] <= '0;
            end
        end else if (up.upValid) begin
            // newest outcome enters at bit 0 and the oldest falls off the top
            histMem[trainIdx] <= {trainHistory[bpPkg::histWidth-2:0], up.upTaken};
        end
    end

endmodule

`default_nettype wire

/* targetBuffer.sv */
`timescale 1ns/10ps
`default_nettype none

module targetBuffer (
    input  logic        clk,
    input  logic        reset,
    input  bpPkg::addrT ifPc,
    output logic        btbHit,
    output bpPkg::addrT btbTarget,
    resolveIf.sink      up
);

    localparam int idxLo = 2;                              // word aligned
    localparam int idxHi = idxLo + bpPkg::indexWidth - 1;

    logic [bpPkg::tableDepth-1:0] validBits;
    logic [bpPkg::tagWidth-1:0]   tagMem [bpPkg::tableDepth];
    bpPkg::addrT                  targetMem [bpPkg::tableDepth];

    logic [bpPkg::indexWidth-1:0] fetchIdx;
    logic [bpPkg::indexWidth-1:0] writeIdx;
    logic [bpPkg::tagWidth-1:0]   fetchTag;
    logic [bpPkg::tagWidth-1:0]   writeTag;
    logic                         doWrite;

    assign fetchIdx = ifPc[idxHi:idxLo];
    assign fetchTag = ifPc[bpPkg::addrWidth-1 -: bpPkg::tagWidth];
    assign writeIdx = up.upPc[idxHi:idxLo];
    assign writeTag = up.upPc[bpPkg::addrWidth-1 -: bpPkg::tagWidth];

    // only taken branches are worth an entry
    assign doWrite = up.upValid && up.upTaken;

    // lookup
    assign btbHit    = validBits[fetchIdx] && (tagMem[fetchIdx] == fetchTag);
    assign btbTarget = targetMem[fetchIdx];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            validBits <= '0;
        end else if (doWrite) begin
            validBits[writeIdx] <= 1'b1;
        end
    end

    // tag and target storage
    always_ff @(posedge clk) begin
        if (doWrite) begin
            tagMem[writeIdx]    <= writeTag;
            targetMem[writeIdx] <= up.upTarget;   // overwrites any aliasing branch
        end
    end

endmodule

`default_nettype wire

/* resolveCapture.sv */
`timescale 1ns/10ps
`default_nettype none

module resolveCapture (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       exBranch,
    input  logic                       taken,
    input  bpPkg::addrT                exPc,
    input  bpPkg::addrT                branchTarget,
    input  logic                       ifPred,
    input  logic                       ifPredValid,
    output logic                       redirect,
    output bpPkg::addrT                redirectPc,
    output logic [bpPkg::cntWidth-1:0] branchCount,
    output logic [bpPkg::cntWidth-1:0] mispredictCount,
    resolveIf.source                   up
);

    logic unpredicted;
    logic mustNotBranch;
    logic mustBranch;

    // the three ways a resolution disagrees with fetch
    assign unpredicted   = !ifPredValid && taken;            // no btb entry yet
    assign mustNotBranch = ifPredValid && ifPred && !taken;
    assign mustBranch    = ifPredValid && !ifPred && taken;

    assign redirect   = exBranch && (unpredicted || mustNotBranch || mustBranch);
    assign redirectPc = taken ? branchTarget : exPc + bpPkg::pcStep;

    // strobe for table training
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            up.upValid <= 1'b0;
        end else begin
            up.upValid <= exBranch;
        end
    end

    // payload rides along with the strobe
    always_ff @(posedge clk) begin
        up.upPc     <= exPc;
        up.upTarget <= branchTarget;
        up.upTaken  <= taken;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            branchCount     <= '0;
            mispredictCount <= '0;
        end else begin
            if (exBranch)
                branchCount <= branchCount + 1'b1;         // wraps
            if (redirect)
                mispredictCount <= mispredictCount + 1'b1;
        end
    end

    // back to back strobes only from back to back resolutions
    upValidSingle: assert property (@(posedge clk) disable iff (!reset)
        (up.upValid && $past(up.upValid)) |-> ($past(exBranch) && $past(exBranch, 2)));

endmodule

`default_nettype wire

/* resolveIf.sv */
`timescale 1ns/10ps
`default_nettype none

// registered branch resolution with one strobe per resolved branch
interface resolveIf;

    logic        upValid;   // single cycle strobe
    bpPkg::addrT upPc;      // address of the resolved branch
    bpPkg::addrT upTarget;  // where it goes when taken
    logic        upTaken;   // actual outcome

    modport source (
        output upValid,
        output upPc,
        output upTarget,
        output upTaken
    );

    // tables only listen and nothing flows back
    modport sink (
        input upValid,
        input upPc,
        input upTarget,
        input upTaken
    );

endinterface

`default_nettype wire

/* bpPkg.sv */
`default_nettype none

package bpPkg;

    // address and indexing
    localparam int addrWidth  = 32;
    localparam int indexWidth = 8;                     // fetch bits 9:2
    localparam int tableDepth = 1 << indexWidth;       // btb and bht entries
    localparam int tagWidth   = addrWidth - indexWidth - 2;

    // local history and pattern table
    localparam int histWidth = 4;
    localparam int phtDepth  = 1 << histWidth;         // one counter per history

    // statistics
    localparam int cntWidth = 16;

    typedef logic [addrWidth-1:0] addrT;
    typedef logic [1:0]           ctrT;

    // two-bit counter encoding where msb set means taken
    localparam ctrT ctrStrongNotTaken = 2'b00;
    localparam ctrT ctrWeakNotTaken   = 2'b01;         // reset value
    localparam ctrT ctrWeakTaken      = 2'b10;
    localparam ctrT ctrStrongTaken    = 2'b11;

    // fetch address constants
    localparam addrT pcResetValue = '0;
    localparam addrT pcStep       = addrT'(4);         // one instruction

endpackage

`default_nettype wire
